// ==== verilog/q_engine_mem_pkg.sv ====
`default_nettype none

package q_engine_mem_pkg;

   localparam int VMEM_DEPTH  = 4096;
   localparam int VMEM_ADDR_W = $clog2(VMEM_DEPTH);  // 12 bits
   localparam int VMEM_DATA_W = 32;

   typedef logic [VMEM_ADDR_W-1:0] vmem_addr_t;
   typedef logic [VMEM_DATA_W-1:0] vmem_word_t;

   // one access per cycle, 45 bits
   typedef struct packed {
      logic       we;
      vmem_addr_t addr;
      vmem_word_t wdata;
   } vmem_req_t;

endpackage

`default_nettype wire

// ==== verilog/q_engine_dma_pkg.sv ====
`default_nettype none

package q_engine_dma_pkg;

   import q_engine_mem_pkg::*;

   localparam int XFER_COUNT_W = 13;  // lengths up to VMEM_DEPTH
   localparam int RETURN_DEPTH = 4;   // return buffer size and credit count
   localparam int RETURN_PTR_W = $clog2(RETURN_DEPTH);
   localparam int CREDIT_W     = $clog2(RETURN_DEPTH + 1);

   typedef logic [XFER_COUNT_W-1:0] xfer_count_t;

   typedef struct packed {
      vmem_addr_t  start;
      xfer_count_t length;
      logic        reverse;
      logic        run_till_last;
   } dma_in_cfg_t;

   typedef struct packed {
      vmem_addr_t  start;
      xfer_count_t length;
      logic        reverse;
      logic        last;
   } dma_out_cfg_t;

   typedef struct packed {
      vmem_word_t data;
      logic       last;
   } stream_t;

   // word k of a transfer, wraps modulo VMEM_DEPTH
   function automatic vmem_addr_t xfer_addr(vmem_addr_t start, xfer_count_t length,
                                            logic reverse, xfer_count_t k);
      xfer_count_t offset;
      offset = reverse ? (length - 1'b1 - k) : k;
      return start + offset[VMEM_ADDR_W-1:0];
   endfunction

endpackage

`default_nettype wire

// ==== verilog/vector_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_memory import q_engine_mem_pkg::*; (
   input  wire            clk,
   input  wire            i_rst_n,
   input  wire vmem_req_t i_req_a,
   input  wire            i_req_a_valid,
   output logic           o_grant_a,
   input  wire vmem_req_t i_req_b,
   input  wire            i_req_b_valid,
   output logic           o_grant_b,
   output vmem_word_t     o_rd_data,
   output logic           o_rd_valid
);

   vmem_word_t mem [VMEM_DEPTH];
   logic       last_b;   // b won the last grant
   vmem_req_t  req_sel;
   logic       req_go;
   logic       rd_go;

   // round robin, the port not granted last wins a tie
   assign o_grant_a = i_req_a_valid & (~i_req_b_valid | last_b);
   assign o_grant_b = i_req_b_valid & (~i_req_a_valid | ~last_b);

   assign req_sel = o_grant_a ? i_req_a : i_req_b;
   assign req_go  = o_grant_a | o_grant_b;
   assign rd_go   = o_grant_b & ~i_req_b.we;  // only port b reads

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         last_b     <= 1'b0;
         o_rd_valid <= 1'b0;
      end else begin
         if (o_grant_a)
            last_b <= 1'b0;
         else if (o_grant_b)
            last_b <= 1'b1;
         o_rd_valid <= rd_go;
      end
   end

   // single address port
   always_ff @(posedge clk) begin
      if (req_go & req_sel.we)
         mem[req_sel.addr] <= req_sel.wdata;
      if (rd_go)
         o_rd_data <= mem[req_sel.addr];
   end

endmodule

`default_nettype wire

// ==== verilog/read_return_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_return_fifo import q_engine_dma_pkg::*; (
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire          i_push,
   input  wire stream_t i_push_word,
   output stream_t      o_pop_word,
   output logic         o_pop_valid,
   input  wire          i_pop_ready,
   output logic         o_popped
);

   stream_t                 buf_q [RETURN_DEPTH];
   logic [RETURN_PTR_W-1:0] wr_ptr;
   logic [RETURN_PTR_W-1:0] rd_ptr;
   logic [CREDIT_W-1:0]     count;

   assign o_pop_valid = (count != '0);
   assign o_pop_word  = buf_q[rd_ptr];
   assign o_popped    = o_pop_valid & i_pop_ready;  // credit back to dma_out

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (o_popped)
            rd_ptr <= rd_ptr + 1'b1;
         case ({i_push, o_popped})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // credits keep this from overflowing
   always_ff @(posedge clk) begin
      if (i_push)
         buf_q[wr_ptr] <= i_push_word;
   end

endmodule

`default_nettype wire

// ==== verilog/dma_in.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_in import q_engine_mem_pkg::*, q_engine_dma_pkg::*; (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire dma_in_cfg_t i_cfg,
   input  wire              i_cfg_valid,
   output logic             o_cfg_ready,
   input  wire stream_t     i_t0,
   input  wire              i_t0_valid,
   output logic             o_t0_ready,
   output vmem_req_t        o_req,
   output logic             o_req_valid,
   input  wire              i_req_grant,
   output xfer_count_t      o_status,
   output logic             o_irq,
   input  wire              i_irq_clear
);

   dma_in_cfg_t cfg;
   logic        busy;
   xfer_count_t wr_cnt;      // also index of the held word
   stream_t     hold;
   logic        hold_valid;
   logic        cfg_go;
   logic        take;
   logic        wr_go;
   logic        final_wr;

   assign o_cfg_ready = ~busy;
   assign cfg_go      = i_cfg_valid & o_cfg_ready;
   assign o_t0_ready  = busy & ~hold_valid;
   assign take        = i_t0_valid & o_t0_ready;
   assign o_req_valid = hold_valid;
   assign wr_go       = hold_valid & i_req_grant;

   // ends on length, or early on last
   assign final_wr = (wr_cnt == cfg.length - 1'b1) | (cfg.run_till_last & hold.last);

   assign o_req = '{we: 1'b1,
                    addr: xfer_addr(cfg.start, cfg.length, cfg.reverse, wr_cnt),
                    wdata: hold.data};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy       <= 1'b0;
         hold_valid <= 1'b0;
         wr_cnt     <= '0;
         o_status   <= '0;
         o_irq      <= 1'b0;
      end else begin
         if (cfg_go) begin
            busy   <= 1'b1;
            wr_cnt <= '0;
         end
         if (take)
            hold_valid <= 1'b1;
         else if (wr_go)
            hold_valid <= 1'b0;
         if (wr_go) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (final_wr) begin
               busy     <= 1'b0;
               o_status <= wr_cnt + 1'b1;
            end
         end
         if (wr_go & final_wr)
            o_irq <= 1'b1;
         else if (i_irq_clear)
            o_irq <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_go)
         cfg <= i_cfg;
      if (take)
         hold <= i_t0;
   end

endmodule

`default_nettype wire

// ==== verilog/dma_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_out import q_engine_mem_pkg::*, q_engine_dma_pkg::*; (
   input  wire               clk,
   input  wire               i_rst_n,
   input  wire dma_out_cfg_t i_cfg,
   input  wire               i_cfg_valid,
   output logic              o_cfg_ready,
   output vmem_req_t         o_req,
   output logic              o_req_valid,
   input  wire               i_req_grant,
   input  wire vmem_word_t   i_rd_data,
   input  wire               i_rd_valid,
   output stream_t           o_i0,
   output logic              o_i0_valid,
   input  wire               i_i0_ready,
   output logic              o_irq,
   input  wire               i_irq_clear
);

   dma_out_cfg_t        cfg;
   logic                busy;
   xfer_count_t         rd_cnt;    // reads granted
   xfer_count_t         out_cnt;   // words delivered
   logic [CREDIT_W-1:0] credits;
   logic                rd_last_q;
   stream_t             rd_word;
   logic                popped;
   logic                cfg_go;
   logic                rd_go;
   logic                final_out;

   assign o_cfg_ready = ~busy;
   assign cfg_go      = i_cfg_valid & o_cfg_ready;

   // no read without a free slot in the return buffer
   assign o_req_valid = busy & (rd_cnt != cfg.length) & (credits != '0);
   assign rd_go       = o_req_valid & i_req_grant;
   assign o_req = '{we: 1'b0,
                    addr: xfer_addr(cfg.start, cfg.length, cfg.reverse, rd_cnt),
                    wdata: '0};

   assign final_out = popped & (out_cnt == cfg.length - 1'b1);
   assign rd_word   = '{data: i_rd_data, last: rd_last_q};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy    <= 1'b0;
         rd_cnt  <= '0;
         out_cnt <= '0;
         credits <= CREDIT_W'(RETURN_DEPTH);
         o_irq   <= 1'b0;
      end else begin
         if (cfg_go) begin
            busy    <= 1'b1;
            rd_cnt  <= '0;
            out_cnt <= '0;
         end
         if (rd_go)
            rd_cnt <= rd_cnt + 1'b1;
         if (popped)
            out_cnt <= out_cnt + 1'b1;
         case ({rd_go, popped})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         if (final_out)
            busy <= 1'b0;
         if (final_out)
            o_irq <= 1'b1;
         else if (i_irq_clear)
            o_irq <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_go)
         cfg <= i_cfg;
      rd_last_q <= cfg.last & (rd_cnt == cfg.length - 1'b1);  // lines up with read data
   end

   read_return_fifo return_fifo_0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_push      (i_rd_valid),
      .i_push_word (rd_word),
      .o_pop_word  (o_i0),
      .o_pop_valid (o_i0_valid),
      .i_pop_ready (i_i0_ready),
      .o_popped    (popped)
   );

endmodule

`default_nettype wire

// ==== verilog/q_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module q_engine import q_engine_mem_pkg::*, q_engine_dma_pkg::*; (
   input  wire          clk,
   input  wire          i_rst_n,
   // input dma
   input  wire dma_in_cfg_t  i_in_cfg,
   input  wire          i_in_cfg_valid,
   output logic         o_in_cfg_ready,
   input  wire stream_t i_t0,
   input  wire          i_t0_valid,
   output logic         o_t0_ready,
   output xfer_count_t  o_in_status,
   output logic         o_in_irq,
   input  wire          i_in_irq_clear,
   // output dma
   input  wire dma_out_cfg_t i_out_cfg,
   input  wire          i_out_cfg_valid,
   output logic         o_out_cfg_ready,
   output stream_t      o_i0,
   output logic         o_i0_valid,
   input  wire          i_i0_ready,
   output logic         o_out_irq,
   input  wire          i_out_irq_clear
);

   vmem_req_t  in_req;
   logic       in_req_valid;
   logic       in_grant;
   vmem_req_t  out_req;
   logic       out_req_valid;
   logic       out_grant;
   vmem_word_t rd_data;
   logic       rd_valid;

   dma_in dma_in_0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cfg       (i_in_cfg),
      .i_cfg_valid (i_in_cfg_valid),
      .o_cfg_ready (o_in_cfg_ready),
      .i_t0        (i_t0),
      .i_t0_valid  (i_t0_valid),
      .o_t0_ready  (o_t0_ready),
      .o_req       (in_req),
      .o_req_valid (in_req_valid),
      .i_req_grant (in_grant),
      .o_status    (o_in_status),
      .o_irq       (o_in_irq),
      .i_irq_clear (i_in_irq_clear)
   );

   dma_out dma_out_0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cfg       (i_out_cfg),
      .i_cfg_valid (i_out_cfg_valid),
      .o_cfg_ready (o_out_cfg_ready),
      .o_req       (out_req),
      .o_req_valid (out_req_valid),
      .i_req_grant (out_grant),
      .i_rd_data   (rd_data),
      .i_rd_valid  (rd_valid),
      .o_i0        (o_i0),
      .o_i0_valid  (o_i0_valid),
      .i_i0_ready  (i_i0_ready),
      .o_irq       (o_out_irq),
      .i_irq_clear (i_out_irq_clear)
   );

   // port a writes from dma_in, port b reads for dma_out
   vector_memory vmem_0 (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_req_a       (in_req),
      .i_req_a_valid (in_req_valid),
      .o_grant_a     (in_grant),
      .i_req_b       (out_req),
      .i_req_b_valid (out_req_valid),
      .o_grant_b     (out_grant),
      .o_rd_data     (rd_data),
      .o_rd_valid    (rd_valid)
   );

endmodule

`default_nettype wire

// ==== verif/q_engine_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module q_engine_checker import q_engine_mem_pkg::*, q_engine_dma_pkg::*; (
   input  wire               clk,
   input  wire               i_rst_n,
   input  wire [127:0]       i_test_name,
   input  wire dma_in_cfg_t  i_in_cfg,
   input  wire               i_in_cfg_valid,
   input  wire               i_in_cfg_ready,
   input  wire stream_t      i_t0,
   input  wire               i_t0_valid,
   input  wire               i_t0_ready,
   input  wire xfer_count_t  i_in_status,
   input  wire               i_in_irq,
   input  wire               i_in_irq_clear,
   input  wire dma_out_cfg_t i_out_cfg,
   input  wire               i_out_cfg_valid,
   input  wire               i_out_cfg_ready,
   input  wire stream_t      i_i0,
   input  wire               i_i0_valid,
   input  wire               i_i0_ready,
   input  wire               i_out_irq,
   input  wire               i_out_irq_clear,
   output int                o_mismatches,
   output int                o_failures
);

   logic [31:0]  model [VMEM_DEPTH];
   logic         written [VMEM_DEPTH];
   dma_in_cfg_t  in_cfg;
   dma_out_cfg_t out_cfg;
   int           in_k;
   int           out_k;
   int           in_expect;   // words sent in the last input transfer
   logic         in_active;
   logic         in_done;
   logic         out_active;
   logic         out_final_q;
   logic         in_irq_q;
   logic         out_irq_q;
   logic         in_clr_q;
   logic         out_clr_q;
   logic         reset_seen;

   // word k lands at start+k, or start+len-1-k when reversed
   function automatic vmem_addr_t word_addr(input int start, input int len, input logic rev,
                                            input int k);
      return vmem_addr_t'((start + (rev ? len - 1 - k : k)) % VMEM_DEPTH);
   endfunction

   task automatic compare(input string what, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %0s %0s expected %0h actual %0h", i_test_name, what, expected, actual);
         o_mismatches++;
      end
   endtask

   task automatic report(input string msg);
      $display("Error in %0s: %0s", i_test_name, msg);
      o_failures++;
   endtask

   // samples on the rising edge, inputs change on the falling one
   always @(posedge clk) begin
      vmem_addr_t a;
      logic       out_final;
      if (!i_rst_n) begin
         o_mismatches = 0;
         o_failures   = 0;
         written      = '{default: 1'b0};
         in_active    = 1'b0;
         in_done      = 1'b0;
         out_active   = 1'b0;
         out_final_q  = 1'b0;
         in_irq_q     = 1'b0;
         out_irq_q    = 1'b0;
         in_clr_q     = 1'b0;
         out_clr_q    = 1'b0;
         reset_seen   = 1'b0;
      end else begin
         out_final = 1'b0;
         if (!reset_seen) begin
            compare("outputs after reset", 64'({6'b000011, 13'd0}),
                    64'({i_t0_ready, i_i0_valid, i_in_irq, i_out_irq,
                         i_in_cfg_ready, i_out_cfg_ready, i_in_status}));
            reset_seen = 1'b1;
         end
         if (i_in_cfg_valid && i_in_cfg_ready) begin
            in_cfg    = i_in_cfg;
            in_k      = 0;
            in_active = 1'b1;
         end
         if (i_t0_valid && i_t0_ready) begin
            if (!in_active) begin
               report("input word accepted with no transfer active");
            end else begin
               a = word_addr(int'(in_cfg.start), int'(in_cfg.length), in_cfg.reverse, in_k);
               model[a]   = i_t0.data;
               written[a] = 1'b1;
               in_k++;
               if (in_k == int'(in_cfg.length) || (in_cfg.run_till_last && i_t0.last)) begin
                  in_active = 1'b0;
                  in_done   = 1'b1;
                  in_expect = in_k;
               end
            end
         end
         if (i_in_irq && !in_irq_q) begin
            if (!in_done)
               report("o_in_irq rose before the input transfer ended");
            else
               compare("o_in_status", 64'(in_expect), 64'(i_in_status));
            in_done = 1'b0;
         end
         if (i_out_cfg_valid && i_out_cfg_ready) begin
            out_cfg    = i_out_cfg;
            out_k      = 0;
            out_active = 1'b1;
         end
         if (i_i0_valid && i_i0_ready) begin
            if (!out_active) begin
               report("output word delivered with no transfer active");
            end else begin
               a = word_addr(int'(out_cfg.start), int'(out_cfg.length), out_cfg.reverse, out_k);
               if (!written[a])
                  report($sformatf("read of address %0h which was never written", a));
               else
                  compare($sformatf("word %0d", out_k),
                          64'({model[a], out_cfg.last && out_k == int'(out_cfg.length) - 1}),
                          64'({i_i0.data, i_i0.last}));
               out_k++;
               if (out_k == int'(out_cfg.length)) begin
                  out_active = 1'b0;
                  out_final  = 1'b1;
               end
            end
         end
         if (out_final_q && !i_out_irq)
            report("o_out_irq did not rise one cycle after the final output word");
         if (i_out_irq && !out_irq_q && !out_final_q)
            report("o_out_irq rose before the final output word");
         if (in_irq_q && !i_in_irq && !in_clr_q)
            report("o_in_irq dropped without a clear");
         if (out_irq_q && !i_out_irq && !out_clr_q)
            report("o_out_irq dropped without a clear");
         if (in_clr_q && i_in_irq)
            report("o_in_irq still high on the cycle after its clear");
         if (out_clr_q && i_out_irq)
            report("o_out_irq still high on the cycle after its clear");
         in_irq_q    = i_in_irq;
         out_irq_q   = i_out_irq;
         in_clr_q    = i_in_irq_clear;
         out_clr_q   = i_out_irq_clear;
         out_final_q = out_final;
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_q_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_q_engine import q_engine_mem_pkg::*, q_engine_dma_pkg::*; ();

   localparam int WAIT_LIMIT = 200;  // cycles

   logic         clk;
   logic         rst_n;
   dma_in_cfg_t  in_cfg;
   logic         in_cfg_valid;
   logic         in_cfg_ready;
   stream_t      t0;
   logic         t0_valid;
   logic         t0_ready;
   xfer_count_t  in_status;
   logic         in_irq;
   logic         in_irq_clear;
   dma_out_cfg_t out_cfg;
   logic         out_cfg_valid;
   logic         out_cfg_ready;
   stream_t      i0;
   logic         i0_valid;
   logic         i0_ready;
   logic         out_irq;
   logic         out_irq_clear;
   logic [127:0] test_name;
   logic [31:0]  lfsr;
   int           tb_errors;
   int           mismatches;
   int           failures;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   q_engine dut (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_in_cfg        (in_cfg),
      .i_in_cfg_valid  (in_cfg_valid),
      .o_in_cfg_ready  (in_cfg_ready),
      .i_t0            (t0),
      .i_t0_valid      (t0_valid),
      .o_t0_ready      (t0_ready),
      .o_in_status     (in_status),
      .o_in_irq        (in_irq),
      .i_in_irq_clear  (in_irq_clear),
      .i_out_cfg       (out_cfg),
      .i_out_cfg_valid (out_cfg_valid),
      .o_out_cfg_ready (out_cfg_ready),
      .o_i0            (i0),
      .o_i0_valid      (i0_valid),
      .i_i0_ready      (i0_ready),
      .o_out_irq       (out_irq),
      .i_out_irq_clear (out_irq_clear)
   );

   q_engine_checker chk (
      .clk             (clk),
      .i_rst_n         (rst_n),
      .i_test_name     (test_name),
      .i_in_cfg        (in_cfg),
      .i_in_cfg_valid  (in_cfg_valid),
      .i_in_cfg_ready  (in_cfg_ready),
      .i_t0            (t0),
      .i_t0_valid      (t0_valid),
      .i_t0_ready      (t0_ready),
      .i_in_status     (in_status),
      .i_in_irq        (in_irq),
      .i_in_irq_clear  (in_irq_clear),
      .i_out_cfg       (out_cfg),
      .i_out_cfg_valid (out_cfg_valid),
      .i_out_cfg_ready (out_cfg_ready),
      .i_i0            (i0),
      .i_i0_valid      (i0_valid),
      .i_i0_ready      (i0_ready),
      .i_out_irq       (out_irq),
      .i_out_irq_clear (out_irq_clear),
      .o_mismatches    (mismatches),
      .o_failures      (failures)
   );

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // all tasks start and end on a falling edge
   task automatic send_in_cfg(inout logic ok);
      int n;
      n = 0;
      while (!in_cfg_ready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!in_cfg_ready) begin
         $display("Timeout: dma_in never became ready for a configuration in %0s", test_name);
         tb_errors++;
         ok = 1'b0;
      end else begin
         in_cfg_valid = 1'b1;
         @(negedge clk);
         in_cfg_valid = 1'b0;
      end
   endtask

   task automatic send_out_cfg(inout logic ok);
      int n;
      n = 0;
      while (!out_cfg_ready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!out_cfg_ready) begin
         $display("Timeout: dma_out never became ready for a configuration in %0s", test_name);
         tb_errors++;
         ok = 1'b0;
      end else begin
         out_cfg_valid = 1'b1;
         @(negedge clk);
         out_cfg_valid = 1'b0;
      end
   endtask

   task automatic send_words(input int count, input int last_at, inout logic ok);
      logic [31:0] d;
      int          n;
      for (int k = 0; k < count && ok; k++) begin
         take_bits(32, d);
         t0 = '{data: d, last: (k == last_at)};
         t0_valid = 1'b1;
         n = 0;
         while (!t0_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
         end
         if (!t0_ready) begin
            $display("Timeout: input word %0d of %0s was never accepted", k, test_name);
            tb_errors++;
            ok = 1'b0;
         end else begin
            @(negedge clk);  // word moves on the rising edge in between
         end
      end
      t0_valid = 1'b0;
   endtask

   // random i_i0_ready while an output transfer runs
   task automatic finish_irq(input logic is_out, input int limit, inout logic ok);
      logic [31:0] r;
      int          n;
      n = 0;
      while (!(is_out ? out_irq : in_irq) && n < limit) begin
         if (is_out) begin
            take_bits(1, r);
            i0_ready = r[0];
         end
         @(negedge clk);
         n++;
      end
      i0_ready = 1'b0;
      if (!(is_out ? out_irq : in_irq)) begin
         $display("Timeout: no completion interrupt for %0s", test_name);
         tb_errors++;
         ok = 1'b0;
      end else begin
         repeat (3) @(negedge clk);
         in_irq_clear  = ~is_out;
         out_irq_clear = is_out;
         @(negedge clk);
         in_irq_clear  = 1'b0;
         out_irq_clear = 1'b0;
         @(negedge clk);
      end
   endtask

   task automatic run_pattern(input int fd, input logic [127:0] name, inout logic ok);
      logic [31:0] dir;
      logic [31:0] start;
      logic [63:0] last_s;
      int          len;
      int          rev;
      int          flag;
      int          last_at;
      int          count;
      int          n;
      n = $fscanf(fd, "%s %h %d %d %d %s", dir, start, len, rev, flag, last_s);
      if (n != 6 || len < 1 || len > VMEM_DEPTH) begin
         $display("Error: the pattern line for %0s is malformed", name);
         tb_errors++;
         ok = 1'b0;
      end else begin
         test_name = name;
         last_at   = -1;
         if (last_s != 64'("none"))
            n = $sscanf(last_s, "%d", last_at);
         if (dir == 32'("IN")) begin
            count  = (flag != 0 && last_at >= 0 && last_at < len) ? last_at + 1 : len;
            in_cfg = '{start: start[VMEM_ADDR_W-1:0], length: len[XFER_COUNT_W-1:0],
                       reverse: rev[0], run_till_last: flag[0]};
            send_in_cfg(ok);
            if (ok)
               send_words(count, last_at, ok);
            if (ok)
               finish_irq(1'b0, WAIT_LIMIT, ok);
         end else if (dir == 32'("OUT")) begin
            out_cfg = '{start: start[VMEM_ADDR_W-1:0], length: len[XFER_COUNT_W-1:0],
                        reverse: rev[0], last: flag[0]};
            send_out_cfg(ok);
            if (ok)
               finish_irq(1'b1, WAIT_LIMIT + 8 * len, ok);
         end else begin
            $display("Error: pattern %0s has an unknown direction", name);
            tb_errors++;
            ok = 1'b0;
         end
      end
   endtask

   initial begin
      int           fd;
      int           n;
      logic         ok;
      logic         done;
      logic [127:0] tok;
      logic [799:0] rest;
      lfsr          = 32'h19f9_2a98;
      tb_errors     = 0;
      rst_n         = 1'b0;
      in_cfg        = '0;
      in_cfg_valid  = 1'b0;
      t0            = '0;
      t0_valid      = 1'b0;
      in_irq_clear  = 1'b0;
      out_cfg       = '0;
      out_cfg_valid = 1'b0;
      i0_ready      = 1'b0;
      out_irq_clear = 1'b0;
      test_name     = 128'("reset");
      ok            = 1'b1;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      fd = $fopen("verif/q_engine_patterns.txt", "r");
      if (fd == 0) begin
         $display("Error: cannot open verif/q_engine_patterns.txt");
         tb_errors++;
      end
      done = (fd == 0);
      while (!done && ok) begin
         n = $fscanf(fd, "%s", tok);
         if (n != 1)
            done = 1'b1;
         else if (tok == 128'("#"))
            n = $fgets(rest, fd);  // comment line
         else
            run_pattern(fd, tok, ok);
      end
      if (fd != 0)
         $fclose(fd);
      repeat (4) @(negedge clk);
      $display("errors: %0d mismatches, %0d other checker errors, %0d testbench errors",
               mismatches, failures, tb_errors);
      if (mismatches == 0 && failures == 0 && tb_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/q_engine_patterns.txt ====
# name dir start(hex) length(dec) reverse flag last_at
# flag is run-till-last for IN and last for OUT, last_at is a word index or none
fwd_wr IN 010 16 0 0 none
fwd_rd OUT 010 16 0 1 none
fwd_rd_nolast OUT 010 16 0 0 none
rev_wr IN 100 12 1 0 none
rev_rd OUT 100 12 0 1 none
wrap_wr IN ffa 12 1 0 none
wrap_rd OUT ffa 12 0 1 none
wrap_rd_rev OUT ffa 12 1 0 none
fill_wr IN 200 20 0 0 none
early_wr IN 200 20 0 1 6
early_rd OUT 200 20 0 1 none
fill_rev_wr IN 300 10 0 0 none
early_rev_wr IN 300 10 1 1 3
early_rev_rd OUT 300 10 0 1 none
last_off_wr IN 400 8 0 0 2
last_off_rd OUT 400 8 0 0 none
long_wr IN 800 64 0 0 none
long_rd OUT 800 64 1 1 none
single_wr IN fff 1 0 0 none
single_rd OUT fff 1 1 1 none

// ==== list.f ====
verilog/q_engine_mem_pkg.sv
verilog/q_engine_dma_pkg.sv
verilog/vector_memory.sv
verilog/read_return_fifo.sv
verilog/dma_in.sv
verilog/dma_out.sv
verilog/q_engine.sv
verif/q_engine_checker.sv
verif/tb_q_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_q_engine
RTL_TOP   ?= q_engine
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
